// ==== all.f ====
verilog/julia_pkg.sv
verilog/julia_regs.sv
verilog/pixel_dispatcher.sv
verilog/julia_worker.sv
verilog/frame_arbiter.sv
verilog/julia_top.sv
bench/julia_properties.sv
bench/tb_julia_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_julia_top -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_julia_top.sv ====
`timescale 1ns/1ps

module tb_julia_top;
	import julia_pkg::*;

	localparam int NUM_WORKERS = 3;
	localparam int IMG_W       = 16;
	localparam int IMG_H       = 12;
	localparam int MAX_ITER    = 32;
	localparam int NUM_PIX     = IMG_W * IMG_H;
	localparam int CYCLE_LIMIT = 2 * (NUM_PIX * (MAX_ITER + 4) + 200); // two frames

	localparam logic [FIX_W-1:0] STEP_VAL = 22'h000040; // 1/32 per pixel
	localparam logic [FIX_W-1:0] C1_RE    = 22'h3FFC00; // -0.5
	localparam logic [FIX_W-1:0] C1_IM    = 22'h000200; // 0.25
	localparam logic [FIX_W-1:0] C2_RE    = 22'h000000;
	localparam logic [FIX_W-1:0] C2_IM    = 22'h3FFB00; // -0.625

	logic                tb_clk;
	logic                arst_n;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [7:0]          paddr;
	logic [31:0]         pwdata;
	logic [31:0]         prdata;
	logic                pready;
	logic                fb_valid;
	logic [ADDR_W-1:0]   fb_addr;
	logic [COLOR_W-1:0]  fb_data;
	logic                fb_ready;

	int                  seed = 84001;
	int                  cycles = 0;
	int                  writes_seen;
	bit                  frame_done_seen;
	int                  wr_count [NUM_PIX];   // scoreboard, writes per address
	logic [COLOR_W-1:0]  expected [NUM_PIX];

	julia_top #(
		.NUM_WORKERS (NUM_WORKERS),
		.IMG_W       (IMG_W),
		.IMG_H       (IMG_H),
		.MAX_ITER    (MAX_ITER)
	) i_dut (
		.tb_clk   (tb_clk),
		.arst_n   (arst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.fb_valid (fb_valid),
		.fb_addr  (fb_addr),
		.fb_data  (fb_data),
		.fb_ready (fb_ready)
	);

	always #2 tb_clk = ~tb_clk;

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	// keep the low 22 bits as a signed number
	function automatic longint to_fix(input longint v);
		logic signed [FIX_W-1:0] t;
		t = v[FIX_W-1:0];
		return longint'(t);
	endfunction

	// escape time colour of one pixel, z <- z^2 + c
	function automatic logic [COLOR_W-1:0] model_color(input int px, input int py,
			input logic [FIX_W-1:0] cre, input logic [FIX_W-1:0] cim,
			input logic [FIX_W-1:0] st);
		longint zr;
		longint zi;
		longint rr;
		longint ii;
		longint ri;
		int     n;
		int     result;
		zr = to_fix((px - IMG_W / 2) * to_fix(longint'(st)));
		zi = to_fix((py - IMG_H / 2) * to_fix(longint'(st)));
		n = 0;
		result = -1;
		while (result < 0) begin
			rr = (zr * zr) >>> FIX_FRAC;
			ii = (zi * zi) >>> FIX_FRAC;
			ri = (zr * zi) >>> FIX_FRAC;
			if (n == MAX_ITER)
				result = 0; // never escaped
			else if (rr + ii > (longint'(4) <<< FIX_FRAC))
				result = n % 64;
			else begin
				zr = to_fix(rr - ii + to_fix(longint'(cre)));
				zi = to_fix(2 * ri + to_fix(longint'(cim)));
				n++;
			end
		end
		return COLOR_W'(result);
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge tb_clk);
		penable = 1'b1;
		@(negedge tb_clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge tb_clk);
		penable = 1'b1;
		data    = prdata; // value presented at the access edge
		@(negedge tb_clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		apb_read(addr, got);
		assert (got == exp) else begin
			$display("ERR prdata at paddr 0x%02h: got 0x%08h, expected 0x%08h", addr, got, exp);
			abort_run();
		end
	endtask

	task automatic run_frame(input logic [FIX_W-1:0] cre, input logic [FIX_W-1:0] cim);
		logic [31:0] stat;
		writes_seen     = 0;
		frame_done_seen = 1'b0;
		for (int a = 0; a < NUM_PIX; a++) begin
			wr_count[a] = 0;
			expected[a] = model_color(a % IMG_W, a / IMG_W, cre, cim, STEP_VAL);
		end
		apb_write(REG_C_RE, 32'(cre));
		apb_write(REG_C_IM, 32'(cim));
		apb_write(REG_CTRL, 32'h1);
		stat = '0;
		while (!stat[STAT_DONE])
			apb_read(REG_STAT, stat); // done must be clear until the frame ends
		frame_done_seen = 1'b1;
		assert (writes_seen == NUM_PIX) else begin
			$display("ERR writes_seen at done: got 0x%04h, expected 0x%04h", writes_seen, NUM_PIX);
			abort_run();
		end
		for (int a = 0; a < NUM_PIX; a++) begin
			assert (wr_count[a] == 1) else begin
				$display("ERR wr_count for fb_addr 0x%05h: got 0x%0h, expected 0x1", a, wr_count[a]);
				abort_run();
			end
		end
	endtask

	// frame buffer side, ready chosen for the coming edge
	always @(negedge tb_clk) begin
		fb_ready = ($unsigned($random(seed)) % 10) < 7; // about 70% ready
		if (i_dut.i_props.fail_count != 0) begin
			$display("an assertion bound to the DUT ports has failed");
			abort_run();
		end
		if (arst_n && fb_valid && fb_ready) begin
			assert (fb_addr < NUM_PIX) else begin
				$display("ERR fb_addr 0x%05h is outside the frame of 0x%05h pixels", fb_addr, NUM_PIX);
				abort_run();
			end
			assert (!frame_done_seen) else begin
				$display("a frame buffer write arrived after the done bit was seen");
				abort_run();
			end
			assert (wr_count[fb_addr] == 0) else begin
				$display("address 0x%05h was written twice in one frame", fb_addr);
				abort_run();
			end
			assert (fb_data == expected[fb_addr]) else begin
				$display("ERR fb_data at fb_addr 0x%05h: got 0x%02h, expected 0x%02h",
					fb_addr, fb_data, expected[fb_addr]);
				abort_run();
			end
			wr_count[fb_addr]++;
			writes_seen++;
		end
	end

	always @(posedge tb_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the frames did not finish", cycles);
			abort_run();
		end
	end

	initial begin
		tb_clk          = 1'b0;
		arst_n          = 1'b0;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		fb_ready        = 1'b0;
		writes_seen     = 0;
		frame_done_seen = 1'b0;
		for (int a = 0; a < NUM_PIX; a++) begin
			wr_count[a] = 0;
			expected[a] = '0;
		end
		repeat (3) @(negedge tb_clk);
		arst_n = 1'b1;
		@(negedge tb_clk);

		// register round trip, then a hole in the map
		apb_write(REG_C_RE, 32'h0015_A5A5);
		apb_write(REG_C_IM, 32'h002C_3C3C);
		apb_write(REG_STEP, 32'h000A_0F0F);
		check_read(REG_C_RE, 32'h0015_A5A5);
		check_read(REG_C_IM, 32'h002C_3C3C);
		check_read(REG_STEP, 32'h000A_0F0F);
		check_read(8'h20, 32'h0);

		apb_write(REG_STEP, 32'(STEP_VAL));
		run_frame(C1_RE, C1_IM);
		run_frame(C2_RE, C2_IM); // restart with a new c
		@(negedge tb_clk);

		if (i_dut.i_props.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// ==== bench/julia_properties.sv ====
`timescale 1ns/1ps

module julia_properties #(
	parameter int IMG_W = 16,
	parameter int IMG_H = 12
) (
	input logic                            tb_clk,
	input logic                            arst_n,
	input logic                            psel,
	input logic                            penable,
	input logic                            pready,
	input logic                            fb_valid,
	input logic                            fb_ready,
	input logic [julia_pkg::ADDR_W-1:0]    fb_addr,
	input logic [julia_pkg::COLOR_W-1:0]   fb_data
);
	int unsigned fail_count = 0; // failed assertions so far

	// stalled write keeps valid and payload
	a_fb_hold: assert property (@(posedge tb_clk) disable iff (!arst_n)
		fb_valid && !fb_ready |=> fb_valid && $stable(fb_addr) && $stable(fb_data))
		else begin
			fail_count++;
			$error("fb_valid, fb_addr or fb_data moved during a stall");
		end

	a_fb_reset: assert property (@(posedge tb_clk) !arst_n |-> !fb_valid)
		else begin
			fail_count++;
			$error("fb_valid high in reset");
		end

	a_fb_after_reset: assert property (@(posedge tb_clk) $rose(arst_n) |-> !fb_valid)
		else begin
			fail_count++;
			$error("fb_valid high right after reset");
		end

	a_fb_range: assert property (@(posedge tb_clk) disable iff (!arst_n)
		fb_valid |-> fb_addr < IMG_W * IMG_H)
		else begin
			fail_count++;
			$error("fb_addr 0x%05h beyond the frame", fb_addr);
		end

	// apb access completes without wait states
	a_apb_ready: assert property (@(posedge tb_clk) disable iff (!arst_n)
		psel && penable |-> pready)
		else begin
			fail_count++;
			$error("pready low in an access cycle");
		end

endmodule

bind julia_top julia_properties #(
	.IMG_W (IMG_W),
	.IMG_H (IMG_H)
) i_props (
	.tb_clk   (tb_clk),
	.arst_n   (arst_n),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.fb_valid (fb_valid),
	.fb_ready (fb_ready),
	.fb_addr  (fb_addr),
	.fb_data  (fb_data)
);

// ==== verilog/julia_top.sv ====
`timescale 1ns/1ps

module julia_top #(
	parameter int NUM_WORKERS = 3,
	parameter int IMG_W       = 16,
	parameter int IMG_H       = 12,
	parameter int MAX_ITER    = 32
) (
	input  logic                            tb_clk,
	input  logic                            arst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [7:0]                      paddr,
	input  logic [31:0]                     pwdata,
	output logic [31:0]                     prdata,
	output logic                            pready,
	output logic                            fb_valid,
	output logic [julia_pkg::ADDR_W-1:0]    fb_addr,
	output logic [julia_pkg::COLOR_W-1:0]   fb_data,
	input  logic                            fb_ready
);
	import julia_pkg::*;

	fix_t                   c_re;
	fix_t                   c_im;
	fix_t                   step;
	logic                   frame_start;
	logic                   frame_busy;
	logic                   frame_done_pulse;
	logic [NUM_WORKERS-1:0] pix_start;
	logic [NUM_WORKERS-1:0] idle;
	logic [NUM_WORKERS-1:0] req;
	logic [NUM_WORKERS-1:0] grant;
	logic [COORD_W-1:0]     pix_x;
	logic [COORD_W-1:0]     pix_y;
	logic [ADDR_W-1:0]      w_addr [NUM_WORKERS];
	logic [COLOR_W-1:0]     w_color [NUM_WORKERS];

	julia_regs i_regs (
		.tb_clk           (tb_clk),
		.arst_n           (arst_n),
		.psel             (psel),
		.penable          (penable),
		.pwrite           (pwrite),
		.paddr            (paddr),
		.pwdata           (pwdata),
		.frame_busy       (frame_busy),
		.frame_done_pulse (frame_done_pulse),
		.prdata           (prdata),
		.pready           (pready),
		.c_re             (c_re),
		.c_im             (c_im),
		.step             (step),
		.frame_start      (frame_start)
	);

	pixel_dispatcher #(
		.NUM_WORKERS (NUM_WORKERS),
		.IMG_W       (IMG_W),
		.IMG_H       (IMG_H)
	) i_dispatcher (
		.tb_clk           (tb_clk),
		.arst_n           (arst_n),
		.frame_start      (frame_start),
		.idle             (idle),
		.pix_start        (pix_start),
		.pix_x            (pix_x),
		.pix_y            (pix_y),
		.frame_busy       (frame_busy),
		.frame_done_pulse (frame_done_pulse)
	);

	// one worker per slot, all share the coordinate bus
	for (genvar g = 0; g < NUM_WORKERS; g++) begin : g_worker
		julia_worker #(
			.IMG_W    (IMG_W),
			.IMG_H    (IMG_H),
			.MAX_ITER (MAX_ITER)
		) i_worker (
			.tb_clk (tb_clk),
			.arst_n (arst_n),
			.start  (pix_start[g]),
			.x      (pix_x),
			.y      (pix_y),
			.c_re   (c_re),
			.c_im   (c_im),
			.step   (step),
			.grant  (grant[g]),
			.idle   (idle[g]),
			.req    (req[g]),
			.addr   (w_addr[g]),
			.color  (w_color[g])
		);
	end

	frame_arbiter #(
		.NUM_WORKERS (NUM_WORKERS)
	) i_arbiter (
		.tb_clk   (tb_clk),
		.arst_n   (arst_n),
		.req      (req),
		.addr     (w_addr),
		.color    (w_color),
		.fb_ready (fb_ready),
		.grant    (grant),
		.fb_valid (fb_valid),
		.fb_addr  (fb_addr),
		.fb_data  (fb_data)
	);

endmodule

// ==== verilog/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter #(
	parameter int NUM_WORKERS = 3
) (
	input  logic                            tb_clk,
	input  logic                            arst_n,
	input  logic [NUM_WORKERS-1:0]          req,
	input  logic [julia_pkg::ADDR_W-1:0]    addr [NUM_WORKERS],
	input  logic [julia_pkg::COLOR_W-1:0]   color [NUM_WORKERS],
	input  logic                            fb_ready,
	output logic [NUM_WORKERS-1:0]          grant,
	output logic                            fb_valid,
	output logic [julia_pkg::ADDR_W-1:0]    fb_addr,
	output logic [julia_pkg::COLOR_W-1:0]   fb_data
);
	localparam int IDX_W = (NUM_WORKERS > 1) ? $clog2(NUM_WORKERS) : 1;

	logic [IDX_W-1:0] ptr;    // last granted worker
	logic [IDX_W-1:0] held;
	logic             locked; // stalled write, keep the same worker
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] cand;
	logic [IDX_W-1:0] sel;
	logic             found;

	// search starts one past the last winner
	always_comb begin
		pick  = ptr;
		cand  = ptr;
		found = 1'b0;
		for (int i = 1; i <= NUM_WORKERS; i++) begin
			cand = IDX_W'((int'(ptr) + i) % NUM_WORKERS);
			if (!found && req[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
	end

	assign sel      = locked ? held : pick;
	assign fb_valid = req[sel];
	assign fb_addr  = addr[sel];
	assign fb_data  = color[sel];

	always_comb begin
		grant = '0;
		if (fb_valid && fb_ready)
			grant[sel] = 1'b1;
	end

	always_ff @(posedge tb_clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr    <= IDX_W'(NUM_WORKERS - 1); // worker 0 wins first
			held   <= '0;
			locked <= 1'b0;
		end else if (fb_valid && fb_ready) begin
			ptr    <= sel;
			locked <= 1'b0;
		end else if (fb_valid) begin
			held   <= sel;
			locked <= 1'b1;
		end
	end

endmodule

// ==== verilog/julia_worker.sv ====
`timescale 1ns/1ps

module julia_worker #(
	parameter int IMG_W    = 16,
	parameter int IMG_H    = 12,
	parameter int MAX_ITER = 32
) (
	input  logic                            tb_clk,
	input  logic                            arst_n,
	input  logic                            start,
	input  logic [julia_pkg::COORD_W-1:0]   x,
	input  logic [julia_pkg::COORD_W-1:0]   y,
	input  julia_pkg::fix_t                 c_re,
	input  julia_pkg::fix_t                 c_im,
	input  julia_pkg::fix_t                 step,
	input  logic                            grant,
	output logic                            idle,
	output logic                            req,
	output logic [julia_pkg::ADDR_W-1:0]    addr,
	output logic [julia_pkg::COLOR_W-1:0]   color
);
	import julia_pkg::*;

	localparam int ITER_W = $clog2(MAX_ITER + 1);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_LOAD = 3'd1;
	localparam logic [2:0] S_ITER = 3'd2;
	localparam logic [2:0] S_FMT  = 3'd3;
	localparam logic [2:0] S_WAIT = 3'd4;

	// escape radius squared, 4.0
	localparam logic signed [2*FIX_W-1:0] ESC_LIM = 4 << FIX_FRAC;

	logic [2:0]                 state;
	logic [ITER_W-1:0]          iter;
	logic [COORD_W-1:0]         x_q;
	logic [COORD_W-1:0]         y_q;
	fix_t                       zr;
	fix_t                       zi;
	logic signed [COORD_W:0]    dx;
	logic signed [COORD_W:0]    dy;
	logic signed [FIX_W+COORD_W:0] z0_re;
	logic signed [FIX_W+COORD_W:0] z0_im;
	logic signed [2*FIX_W-1:0]  p_rr;
	logic signed [2*FIX_W-1:0]  p_ii;
	logic signed [2*FIX_W-1:0]  p_ri;
	logic signed [2*FIX_W-1:0]  sq_rr;
	logic signed [2*FIX_W-1:0]  sq_ii;
	logic signed [2*FIX_W-1:0]  sq_ri;
	logic signed [2*FIX_W-1:0]  nr;
	logic signed [2*FIX_W-1:0]  ni;
	logic                       escaped;
	logic                       at_limit;

	// pixel offset from image centre, times step
	assign dx    = $signed({1'b0, x_q}) - $signed((COORD_W+1)'(IMG_W / 2));
	assign dy    = $signed({1'b0, y_q}) - $signed((COORD_W+1)'(IMG_H / 2));
	assign z0_re = dx * step;
	assign z0_im = dy * step;

	assign p_rr  = zr * zr;
	assign p_ii  = zi * zi;
	assign p_ri  = zr * zi;
	assign sq_rr = p_rr >>> FIX_FRAC;
	assign sq_ii = p_ii >>> FIX_FRAC;
	assign sq_ri = p_ri >>> FIX_FRAC;

	assign escaped  = (sq_rr + sq_ii) > ESC_LIM; // test on current z
	assign at_limit = (iter == ITER_W'(MAX_ITER));

	// z <- z^2 + c
	assign nr = sq_rr - sq_ii + c_re;
	assign ni = (sq_ri <<< 1) + c_im;

	assign idle = (state == S_IDLE);
	assign req  = (state == S_WAIT);

	always_ff @(posedge tb_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			iter  <= '0;
		end else begin
			case (state)
				S_IDLE: if (start) state <= S_LOAD;
				S_LOAD: begin
					state <= S_ITER;
					iter  <= '0;
				end
				S_ITER: begin
					if (escaped || at_limit)
						state <= S_FMT;
					else
						iter <= iter + 1'b1;
				end
				S_FMT:  state <= S_WAIT;
				S_WAIT: if (grant) state <= S_IDLE; // write accepted
				default: state <= S_IDLE;
			endcase
		end
	end

	// pixel payload
	always_ff @(posedge tb_clk) begin
		if (state == S_IDLE && start) begin
			x_q <= x;
			y_q <= y;
		end
		if (state == S_LOAD) begin
			zr   <= z0_re[FIX_W-1:0];
			zi   <= z0_im[FIX_W-1:0];
			addr <= ADDR_W'(y_q) * ADDR_W'(IMG_W) + ADDR_W'(x_q);
		end
		if (state == S_ITER && !escaped && !at_limit) begin
			zr <= nr[FIX_W-1:0];
			zi <= ni[FIX_W-1:0];
		end
		if (state == S_FMT)
			color <= at_limit ? '0 : COLOR_W'(iter); // count mod 64
	end

endmodule

// ==== verilog/pixel_dispatcher.sv ====
`timescale 1ns/1ps

module pixel_dispatcher #(
	parameter int NUM_WORKERS = 3,
	parameter int IMG_W       = 16,
	parameter int IMG_H       = 12
) (
	input  logic                            tb_clk,
	input  logic                            arst_n,
	input  logic                            frame_start,
	input  logic [NUM_WORKERS-1:0]          idle,
	output logic [NUM_WORKERS-1:0]          pix_start,
	output logic [julia_pkg::COORD_W-1:0]   pix_x,
	output logic [julia_pkg::COORD_W-1:0]   pix_y,
	output logic                            frame_busy,
	output logic                            frame_done_pulse
);
	import julia_pkg::*;

	localparam logic [NUM_WORKERS-1:0] ONE = 1;

	logic issued_all; // every pixel of the frame handed out
	logic issue;
	logic last_x;
	logic last_y;

	assign last_x = (pix_x == COORD_W'(IMG_W - 1));
	assign last_y = (pix_y == COORD_W'(IMG_H - 1));
	assign issue  = frame_busy && !issued_all && (|idle);

	// lowest set bit of idle picks the worker
	assign pix_start = issue ? (idle & (~idle + ONE)) : '0;

	// last write granted, worker back in idle
	assign frame_done_pulse = frame_busy && issued_all && (&idle);

	always_ff @(posedge tb_clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_busy <= 1'b0;
			issued_all <= 1'b0;
			pix_x      <= '0;
			pix_y      <= '0;
		end else if (frame_start) begin
			frame_busy <= 1'b1;
			issued_all <= 1'b0;
			pix_x      <= '0;
			pix_y      <= '0;
		end else begin
			if (frame_done_pulse)
				frame_busy <= 1'b0;
			if (issue) begin
				if (last_x) begin
					pix_x <= '0;
					if (last_y)
						issued_all <= 1'b1;
					else
						pix_y <= pix_y + 1'b1;
				end else begin
					pix_x <= pix_x + 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/julia_regs.sv ====
`timescale 1ns/1ps

module julia_regs (
	input  logic                 tb_clk,
	input  logic                 arst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [7:0]           paddr,
	input  logic [31:0]          pwdata,
	input  logic                 frame_busy,
	input  logic                 frame_done_pulse,
	output logic [31:0]          prdata,
	output logic                 pready,
	output julia_pkg::fix_t      c_re,
	output julia_pkg::fix_t      c_im,
	output julia_pkg::fix_t      step,
	output logic                 frame_start
);
	import julia_pkg::*;

	logic wr_en;
	logic done;

	assign pready = 1'b1; // no wait states
	assign wr_en  = psel && penable && pwrite;

	always_ff @(posedge tb_clk or negedge arst_n) begin
		if (!arst_n) begin
			c_re        <= '0;
			c_im        <= '0;
			step        <= '0;
			frame_start <= 1'b0;
			done        <= 1'b0;
		end else begin
			frame_start <= 1'b0; // one cycle pulse
			if (frame_done_pulse)
				done <= 1'b1;
			if (wr_en) begin
				case (paddr)
					REG_C_RE: c_re <= pwdata[FIX_W-1:0];
					REG_C_IM: c_im <= pwdata[FIX_W-1:0];
					REG_STEP: step <= pwdata[FIX_W-1:0];
					REG_CTRL: begin
						// a start during a running frame is dropped
						if (pwdata[CTRL_START] && !frame_busy && !frame_start) begin
							frame_start <= 1'b1;
							done        <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// read data only looks at the address
	always_comb begin
		prdata = '0;
		case (paddr)
			REG_C_RE: prdata = {{(32-FIX_W){1'b0}}, c_re};
			REG_C_IM: prdata = {{(32-FIX_W){1'b0}}, c_im};
			REG_STEP: prdata = {{(32-FIX_W){1'b0}}, step};
			REG_STAT: begin
				prdata[STAT_BUSY] = frame_busy;
				prdata[STAT_DONE] = done;
			end
			default: prdata = '0; // ctrl and holes
		endcase
	end

endmodule

// ==== verilog/julia_pkg.sv ====
package julia_pkg;

	// signed fixed point, 11 integer and 11 fraction bits
	localparam int FIX_W    = 22;
	localparam int FIX_FRAC = 11;

	typedef logic signed [FIX_W-1:0] fix_t;

	localparam int COLOR_W = 6;   // colour per pixel
	localparam int COORD_W = 10;  // pixel x or y
	localparam int ADDR_W  = 20;  // frame buffer word address

	// apb register map, byte offsets
	localparam logic [7:0] REG_C_RE = 8'h00;
	localparam logic [7:0] REG_C_IM = 8'h04;
	localparam logic [7:0] REG_STEP = 8'h08;
	localparam logic [7:0] REG_CTRL = 8'h0C; // bit 0 start, self clearing
	localparam logic [7:0] REG_STAT = 8'h10; // bit 0 busy, bit 1 done

	// bit positions inside ctrl and stat
	localparam int CTRL_START = 0;
	localparam int STAT_BUSY  = 0;
	localparam int STAT_DONE  = 1;

endpackage
